// ==== hw/obj_pkg.sv ====
// sprite scanner definitions: table layout, attribute fields, fsm states, draw record widths
package obj_pkg;

    // one table entry is four words: x, y, code, attr at 4k .. 4k+3
    localparam int ENTRY_WORDS  = 4;
    localparam int WORD_W       = 16;
    localparam int LINE_W       = 9;   // scanline and hpos range
    localparam int TILE_SIZE    = 16;  // pixels per tile side
    localparam int TILE_FIELD_W = 4;

    // attribute word, lsb of each field
    localparam int ATTR_TILE_M = 12;   // vertical tiles minus one
    localparam int ATTR_TILE_N = 8;    // horizontal tiles minus one
    localparam int ATTR_VFLIP  = 6;
    localparam int ATTR_HFLIP  = 5;    // palette sits in 4:0

    // draw record
    localparam int CODE_W = 16;
    localparam int ATTR_W = 16;
    localparam int HPOS_W = 9;

    typedef enum logic [3:0] {
        st_idle, st_read_attr, st_read_code, st_read_y, st_read_x,
        st_map_code, st_test_zone, st_issue, st_release, st_next_tile
    } obj_state_e;

endpackage

// ==== hw/gfx_pkg.sv ====
// rom bank mapper definitions shared by the scanner and the top level
package gfx_pkg;

    // board variants
    typedef enum logic [5:0] {
        game_plain  = 6'd0,   // flat rom, no banking
        game_banked = 6'd1    // four bank regions
    } game_e;

    localparam int BANK_FIELD   = 4;                        // one nibble per region
    localparam int BANK_REGIONS = 4;
    localparam int BANK_W       = BANK_FIELD * BANK_REGIONS;

    // upper code bits seen by the mapper, code[15:6]
    localparam int CODE_HI_W = 10;

endpackage

// ==== hw/obj_draw_if.sv ====
// draw request channel from the line scanner to the tile output stage
`timescale 1ns/1ps

interface obj_draw_if;

    logic                        start;  // one cycle strobe
    logic [obj_pkg::CODE_W-1:0]  code;
    logic [obj_pkg::ATTR_W-1:0]  attr;   // row-in-tile in 11:8
    logic [obj_pkg::HPOS_W-1:0]  hpos;
    logic                        idle;   // sink can take a record

    modport scan (
        output start, code, attr, hpos,
        input  idle
    );

    modport sink (
        input  start, code, attr, hpos,
        output idle
    );

endinterface

// ==== hw/obj_frame_ram.sv ====
// sprite frame table, host write port and registered scanner read port
`timescale 1ns/1ps

module obj_frame_ram #(
    parameter  int OBJ_COUNT = 256,
    localparam int DEPTH     = OBJ_COUNT * obj_pkg::ENTRY_WORDS,
    localparam int AW        = $clog2(DEPTH)
) (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [AW-1:0]              wr_addr,
    input  logic [obj_pkg::WORD_W-1:0] wr_data,
    input  logic [AW-1:0]              rd_addr,
    output logic [obj_pkg::WORD_W-1:0] rd_data
);

    logic [obj_pkg::WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;  // host side
        end
        rd_data <= mem[rd_addr];      // one cycle read latency
    end

endmodule

// ==== hw/gfx_bank_mapper.sv ====
// registered rom bank lookup, upper code bits to bank offset, mask and unmapped flag
`timescale 1ns/1ps

module gfx_bank_mapper (
    input  logic                            clk,
    input  logic                            rst,
    input  gfx_pkg::game_e                  game,
    input  logic [gfx_pkg::BANK_W-1:0]      bank_offset,
    input  logic [gfx_pkg::BANK_W-1:0]      bank_mask,
    input  logic [gfx_pkg::CODE_HI_W-1:0]   code_hi,
    output logic [gfx_pkg::BANK_FIELD-1:0]  offset,
    output logic [gfx_pkg::BANK_FIELD-1:0]  mask,
    output logic                            unmapped
);

    localparam int FW = gfx_pkg::BANK_FIELD;
    localparam int RW = $clog2(gfx_pkg::BANK_REGIONS);

    logic [RW-1:0] region;
    logic [FW-1:0] reg_offset;
    logic [FW-1:0] reg_mask;

    // region comes from code[15:14]
    assign region     = code_hi[gfx_pkg::CODE_HI_W-1 -: RW];
    assign reg_offset = bank_offset[region*FW +: FW];
    assign reg_mask   = bank_mask[region*FW +: FW];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset   <= '0;
            mask     <= '0;
            unmapped <= 1'b0;
        end else if (game == gfx_pkg::game_banked) begin
            offset   <= reg_offset;
            mask     <= reg_mask;
            unmapped <= (reg_mask == '0);  // empty mask, no rom behind it
        end else begin
            offset   <= '0;   // flat rom passes the code through
            mask     <= '1;
            unmapped <= 1'b0;
        end
    end

endmodule

// ==== hw/obj_row_match.sv ====
// tile row comparator that the line scanner instantiates once for every row of a sprite
`timescale 1ns/1ps

module obj_row_match #(
    parameter int ROW = 0
) (
    input  logic                             clk,
    input  logic [obj_pkg::TILE_FIELD_W-1:0] tile_m,
    input  logic [obj_pkg::LINE_W-1:0]       line,
    input  logic [obj_pkg::LINE_W-1:0]       obj_y,
    output logic                             match
);

    logic [obj_pkg::LINE_W-1:0] dy;

    assign dy = line - obj_y;  // wraps at 512 like the line counter

    always_ff @(posedge clk) begin
        // row must exist in the sprite and hold the line
        match <= (ROW <= int'(tile_m))
              && (int'(dy) >= ROW * obj_pkg::TILE_SIZE)
              && (int'(dy) < (ROW + 1) * obj_pkg::TILE_SIZE);
    end

endmodule

// ==== hw/obj_line_scan.sv ====
// sprite table walker, tests each entry against the line and issues one draw per tile
`timescale 1ns/1ps

module obj_line_scan #(
    parameter  int OBJ_COUNT = 256,
    localparam int AW        = $clog2(OBJ_COUNT * obj_pkg::ENTRY_WORDS)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flip,
    input  logic [obj_pkg::LINE_W-1:0] line,
    input  logic                       start,
    input  gfx_pkg::game_e             game,
    input  logic [gfx_pkg::BANK_W-1:0] bank_offset,
    input  logic [gfx_pkg::BANK_W-1:0] bank_mask,
    output logic [AW-1:0]              rd_addr,
    input  logic [obj_pkg::WORD_W-1:0] rd_data,
    output logic                       busy,
    obj_draw_if.scan                   draw
);

    localparam int WW = obj_pkg::WORD_W;
    localparam int LW = obj_pkg::LINE_W;
    localparam int TW = obj_pkg::TILE_FIELD_W;
    localparam int HW = obj_pkg::HPOS_W;
    localparam int FW = gfx_pkg::BANK_FIELD;

    obj_pkg::obj_state_e st;
    obj_pkg::obj_state_e next_entry_st;

    logic              rd_wait;     // first word of an entry needs two cycles
    logic              first;       // no duplicate test on the first entry
    logic              last_entry;
    logic [LW-1:0]     linef;
    logic [WW-1:0]     obj_attr, obj_x, obj_y, raw_code, obj_code;
    logic [WW-1:0]     last_attr, last_x, last_y, last_code;
    logic [gfx_pkg::CODE_HI_W-1:0] mapper_in;
    logic [FW-1:0]     offset, mask;
    logic              unmapped;
    logic [(1<<TW)-1:0] match;
    logic [TW-1:0]     tile_m, tile_n, n, npos, row, rterm, vsub;
    logic              vflip, hflip, inzone, repeated, bad_bank;
    logic [LW-1:0]     dy;
    logic [WW-1:0]     code_mn;

    assign tile_m = obj_attr[obj_pkg::ATTR_TILE_M +: TW];
    assign tile_n = obj_attr[obj_pkg::ATTR_TILE_N +: TW];
    assign vflip  = obj_attr[obj_pkg::ATTR_VFLIP];
    assign hflip  = obj_attr[obj_pkg::ATTR_HFLIP];
    assign busy   = (st != obj_pkg::st_idle);

    gfx_bank_mapper u_mapper (
        .clk         (clk),
        .rst         (rst),
        .game        (game),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .code_hi     (mapper_in),
        .offset      (offset),
        .mask        (mask),
        .unmapped    (unmapped)
    );

    for (genvar r = 0; r < (1 << TW); r++) begin : g_row
        obj_row_match #(.ROW(r)) u_row (
            .clk    (clk),
            .tile_m (tile_m),
            .line   (linef),
            .obj_y  (obj_y[LW-1:0]),
            .match  (match[r])
        );
    end

    always_comb begin
        row = '0;
        for (int i = (1 << TW) - 1; i >= 0; i--) begin
            if (match[i]) begin
                row = TW'(i);  // lowest matching row wins
            end
        end
    end

    assign inzone   = |match;
    assign dy       = linef - obj_y[LW-1:0];
    assign vsub     = dy[TW-1:0] ^ {TW{vflip}};   // row inside the tile
    assign rterm    = vflip ? tile_m - row : row;
    assign code_mn  = {obj_code[15:8], obj_code[7:4] + rterm, obj_code[3:0] + n};
    assign repeated = (obj_x == last_x) && (obj_y == last_y)
                   && (raw_code == last_code) && (obj_attr == last_attr);
    assign bad_bank = |(raw_code[WW-1 -: FW] & ~mask);  // bits outside the region
    assign next_entry_st = last_entry ? obj_pkg::st_idle : obj_pkg::st_read_attr;

    // control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= obj_pkg::st_idle;
            rd_addr    <= '0;
            rd_wait    <= 1'b0;
            first      <= 1'b0;
            last_entry <= 1'b0;
            n          <= '0;
            npos       <= '0;
            draw.start <= 1'b0;
        end else begin
            case (st)
                obj_pkg::st_idle: if (start) begin
                    rd_addr    <= AW'(OBJ_COUNT * obj_pkg::ENTRY_WORDS - 1); // top attr
                    rd_wait    <= 1'b1;
                    first      <= 1'b1;
                    last_entry <= 1'b0;
                    st         <= obj_pkg::st_read_attr;
                end
                obj_pkg::st_read_attr: begin
                    rd_addr <= rd_addr - 1'b1;  // code, then y
                    rd_wait <= 1'b0;
                    if (!rd_wait) begin
                        st <= obj_pkg::st_read_code;
                    end
                end
                obj_pkg::st_read_code: begin
                    rd_addr <= rd_addr - 1'b1;  // x
                    st      <= obj_pkg::st_read_y;
                end
                obj_pkg::st_read_y: begin
                    rd_addr    <= rd_addr - 1'b1;      // next entry attr
                    last_entry <= (rd_addr == '0);    // x of entry 0
                    st         <= obj_pkg::st_read_x;
                end
                obj_pkg::st_read_x: begin
                    rd_wait <= 1'b1;
                    st      <= obj_pkg::st_map_code;
                end
                obj_pkg::st_map_code: begin
                    first <= 1'b0;
                    if (unmapped || bad_bank || (repeated && !first)) begin
                        st <= next_entry_st;
                    end else begin
                        st <= obj_pkg::st_test_zone;
                    end
                end
                obj_pkg::st_test_zone: begin
                    n    <= '0;
                    npos <= hflip ? tile_n : '0;  // mirrored sprites start at the right
                    st   <= inzone ? obj_pkg::st_issue : next_entry_st;
                end
                obj_pkg::st_issue: if (draw.idle) begin
                    draw.start <= 1'b1;
                    st         <= obj_pkg::st_release;
                end
                obj_pkg::st_release: begin
                    draw.start <= 1'b0;
                    st         <= obj_pkg::st_next_tile;
                end
                obj_pkg::st_next_tile: begin
                    if (n == tile_n) begin
                        st <= next_entry_st;
                    end else begin
                        n    <= n + 1'b1;
                        npos <= hflip ? npos - 1'b1 : npos + 1'b1;
                        st   <= obj_pkg::st_issue;
                    end
                end
                default: st <= obj_pkg::st_idle;
            endcase
        end
    end

    // entry words and draw record
    always_ff @(posedge clk) begin
        case (st)
            obj_pkg::st_idle: linef <= line ^ {1'b0, {(LW-1){flip}}};
            obj_pkg::st_read_attr: if (!rd_wait) begin
                last_attr <= obj_attr;
                obj_attr  <= rd_data;
            end
            obj_pkg::st_read_code: begin
                last_code <= raw_code;
                raw_code  <= rd_data;
                mapper_in <= rd_data[WW-1 -: gfx_pkg::CODE_HI_W];
            end
            obj_pkg::st_read_y: begin
                last_y <= obj_y;
                obj_y  <= rd_data;
            end
            obj_pkg::st_read_x: begin
                last_x <= obj_x;
                obj_x  <= rd_data;
            end
            obj_pkg::st_map_code: begin
                obj_code <= {(raw_code[WW-1 -: FW] & mask) | offset, raw_code[WW-FW-1:0]};
            end
            obj_pkg::st_issue: if (draw.idle) begin
                draw.code <= code_mn;
                draw.attr <= {4'd0, vsub, obj_attr[7:0]};
                draw.hpos <= obj_x[HW-1:0] + HW'(npos) * HW'(obj_pkg::TILE_SIZE) - HW'(1);
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/obj_tile_out.sv ====
// one entry draw record holder, presents records with valid/ready and reports idle
`timescale 1ns/1ps

module obj_tile_out (
    input  logic                        clk,
    input  logic                        rst,
    obj_draw_if.sink                    draw,
    output logic                        tile_valid,
    input  logic                        tile_ready,
    output logic [obj_pkg::CODE_W-1:0]  tile_code,
    output logic [obj_pkg::ATTR_W-1:0]  tile_attr,
    output logic [obj_pkg::HPOS_W-1:0]  tile_hpos
);

    // scanner only starts while idle, so load and release never collide
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_valid <= 1'b0;
        end else if (draw.start) begin
            tile_valid <= 1'b1;
        end else if (tile_ready) begin
            tile_valid <= 1'b0;   // record taken
        end
    end

    always_ff @(posedge clk) begin
        if (draw.start) begin
            tile_code <= draw.code;
            tile_attr <= draw.attr;
            tile_hpos <= draw.hpos;
        end
    end

    assign draw.idle = ~tile_valid;  // empty holder

endmodule

// ==== hw/obj_line_top.sv ====
// sprite line scanner top, frame ram plus scanner plus output stage on plain ports
`timescale 1ns/1ps

module obj_line_top #(
    parameter  int OBJ_COUNT = 256,
    localparam int AW        = $clog2(OBJ_COUNT * obj_pkg::ENTRY_WORDS)
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flip,
    input  logic [obj_pkg::LINE_W-1:0]  line,
    input  logic                        start,
    input  gfx_pkg::game_e              game,
    input  logic [gfx_pkg::BANK_W-1:0]  bank_offset,
    input  logic [gfx_pkg::BANK_W-1:0]  bank_mask,
    input  logic                        wr_en,
    input  logic [AW-1:0]               wr_addr,
    input  logic [obj_pkg::WORD_W-1:0]  wr_data,
    output logic                        busy,
    output logic                        tile_valid,
    input  logic                        tile_ready,
    output logic [obj_pkg::CODE_W-1:0]  tile_code,
    output logic [obj_pkg::ATTR_W-1:0]  tile_attr,
    output logic [obj_pkg::HPOS_W-1:0]  tile_hpos
);

    logic [AW-1:0]              rd_addr;
    logic [obj_pkg::WORD_W-1:0] rd_data;

    obj_draw_if draw_bus ();

    obj_frame_ram #(.OBJ_COUNT(OBJ_COUNT)) u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    obj_line_scan #(.OBJ_COUNT(OBJ_COUNT)) u_scan (
        .clk         (clk),
        .rst         (rst),
        .flip        (flip),
        .line        (line),
        .start       (start),
        .game        (game),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .busy        (busy),
        .draw        (draw_bus.scan)
    );

    obj_tile_out u_out (
        .clk        (clk),
        .rst        (rst),
        .draw       (draw_bus.sink),
        .tile_valid (tile_valid),
        .tile_ready (tile_ready),
        .tile_code  (tile_code),
        .tile_attr  (tile_attr),
        .tile_hpos  (tile_hpos)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
// testbench clock and reset source for the sprite line scanner, one instance per testbench
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD     = 10.0,  // ns
    parameter int  RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // release just after an edge, like every other input
    end

endmodule

// ==== sim/obj_line_tb.sv ====
// table driven testbench that loads sprite tables into obj_line_top and checks the draw records
`timescale 1ns/1ps

module obj_line_tb;

    localparam int OBJ_COUNT = 16;                          // small table keeps scans short
    localparam int WORDS     = OBJ_COUNT * obj_pkg::ENTRY_WORDS;
    localparam int AW        = $clog2(WORDS);
    localparam int NCASE     = 6;
    localparam int TIMEOUT   = 2000;                        // cycles per wait

    logic clk, rst;
    logic flip, start, wr_en, tile_ready;
    logic [8:0] line;
    gfx_pkg::game_e game;
    logic [15:0] bank_offset, bank_mask, wr_data;
    logic [AW-1:0] wr_addr;
    logic busy, tile_valid;
    logic [15:0] tile_code, tile_attr;
    logic [8:0] tile_hpos;

    // slot s of c_word lands in entry s as x, y, code and attr
    string          c_name  [NCASE];
    logic [15:0]    c_word  [NCASE][16];
    int             c_nspr  [NCASE];
    logic           c_flip  [NCASE];
    logic [8:0]     c_line  [NCASE];
    gfx_pkg::game_e c_game  [NCASE];
    logic [15:0]    c_boff  [NCASE];
    logic [15:0]    c_bmask [NCASE];
    logic [7:0]     c_ready [NCASE];  // ready pattern that repeats every 8 cycles
    logic           c_rand  [NCASE];

    logic [15:0] img [WORDS];         // copy of what the host wrote
    logic [40:0] exp_q [$];           // {code, attr, hpos}
    logic [40:0] got_q [$];
    integer      seed;
    int          errors, case_errs, passed, ci;
    logic        ok, timed_out;

    tb_clk_gen #(.PERIOD(10.0), .RST_CYCLES(5)) u_clk (.clk(clk), .rst(rst));

    obj_line_top #(.OBJ_COUNT(OBJ_COUNT)) u_dut (
        .clk (clk), .rst (rst), .flip (flip), .line (line), .start (start),
        .game (game), .bank_offset (bank_offset), .bank_mask (bank_mask),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
        .busy (busy), .tile_valid (tile_valid), .tile_ready (tile_ready),
        .tile_code (tile_code), .tile_attr (tile_attr), .tile_hpos (tile_hpos)
    );

    task automatic set_case(input int c, input string nm, input logic fl,
                            input logic [8:0] ln, input logic [7:0] rdy);
        int w;
        c_name[c]  = nm;
        c_flip[c]  = fl;
        c_line[c]  = ln;
        c_ready[c] = rdy;
        c_game[c]  = gfx_pkg::game_plain;
        c_boff[c]  = '0;
        c_bmask[c] = '0;
        c_rand[c]  = 1'b0;
        c_nspr[c]  = 0;
        for (w = 0; w < 16; w++) begin
            c_word[c][w] = '0;
        end
    endtask

    task automatic set_sprite(input int c, input int slot, input logic [15:0] x,
                              input logic [15:0] y, input logic [15:0] code,
                              input logic [15:0] attr);
        c_word[c][slot*4]   = x;
        c_word[c][slot*4+1] = y;
        c_word[c][slot*4+2] = code;
        c_word[c][slot*4+3] = attr;
        if (slot + 1 > c_nspr[c]) begin
            c_nspr[c] = slot + 1;
        end
    endtask

    task automatic fill_table();
        int w;
        set_case(0, "single", 1'b0, 9'h035, 8'hFF);
        set_sprite(0, 0, 16'h0040, 16'h0030, 16'h1234, 16'h0003);
        set_case(1, "hexpand", 1'b0, 9'h05A, 8'b1011_0110);
        set_sprite(1, 1, 16'h0020, 16'h0050, 16'h0100, 16'h0201);
        set_sprite(1, 0, 16'h0080, 16'h0050, 16'h0210, 16'h0222);  // hflip
        set_case(2, "vexpand", 1'b1, 9'h09A, 8'hFF);                  // flipped line 0x065
        set_sprite(2, 1, 16'h0100, 16'h0040, 16'h2000, 16'h3004);
        set_sprite(2, 0, 16'h0100, 16'h0040, 16'h3000, 16'h3044);  // vflip
        set_case(3, "skip", 1'b0, 9'h030, 8'b1110_1110);
        set_sprite(3, 2, 16'h0010, 16'h0100, 16'h0500, 16'h0000);  // off the line
        set_sprite(3, 1, 16'h0050, 16'h0028, 16'h0600, 16'h0000);
        set_sprite(3, 0, 16'h0050, 16'h0028, 16'h0600, 16'h0000);  // duplicate
        set_case(4, "banked", 1'b0, 9'h02F, 8'hFF);
        c_game[4]  = gfx_pkg::game_banked;
        c_boff[4]  = 16'h0020;
        c_bmask[4] = 16'hF0C0;                                         // regions 0 and 2 empty
        set_sprite(4, 3, 16'h0040, 16'h0020, 16'h5123, 16'h0001);  // bits outside mask
        set_sprite(4, 2, 16'h0050, 16'h0020, 16'h0789, 16'h0001);  // unmapped only
        set_sprite(4, 1, 16'h0060, 16'h0020, 16'h4123, 16'h0001);
        set_sprite(4, 0, 16'h0070, 16'h0020, 16'h8456, 16'h0001);
        set_case(5, "random_ready", 1'b0, 9'h05A, 8'h00);
        c_rand[5] = 1'b1;
        c_nspr[5] = c_nspr[1];
        for (w = 0; w < 16; w++) begin
            c_word[5][w] = c_word[1][w];  // same sprites as hexpand
        end
    endtask

    // clear the whole table, then write the case sprites through the host port
    task automatic load_case(input int c);
        int a;
        for (a = 0; a < WORDS; a++) begin
            img[a] = (a < c_nspr[c] * 4) ? c_word[c][a] : 16'h0000;
        end
        for (a = 0; a < WORDS; a++) begin
            @(posedge clk);
            #1;
            wr_en   = 1'b1;
            wr_addr = AW'(a);
            wr_data = img[a];
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    // reference model that walks the image from the top entry down
    task automatic build_expected(input int c);
        logic [15:0] x, y, code, attr, px, py, pc, pa, mcode, ecode;
        logic [8:0]  ln, dy, hpos;
        logic [3:0]  off, msk, tm, tn, rt, npos;
        logic        skip, vf, hf;
        int          k, n;
        exp_q.delete();
        ln = c_flip[c] ? {c_line[c][8], ~c_line[c][7:0]} : c_line[c];
        for (k = OBJ_COUNT - 1; k >= 0; k--) begin
            x    = img[4*k];
            y    = img[4*k+1];
            code = img[4*k+2];
            attr = img[4*k+3];
            off  = 4'h0;
            msk  = 4'hF;
            if (c_game[c] == gfx_pkg::game_banked) begin
                off = c_boff[c][code[15:14]*4 +: 4];
                msk = c_bmask[c][code[15:14]*4 +: 4];
            end
            skip = (msk == 4'h0) || ((code[15:12] & ~msk) != 4'h0);
            if (k != OBJ_COUNT - 1 && {x, y, code, attr} == {px, py, pc, pa}) begin
                skip = 1'b1;
            end
            {px, py, pc, pa} = {x, y, code, attr};
            tm = attr[15:12];
            tn = attr[11:8];
            vf = attr[6];
            hf = attr[5];
            dy = ln - y[8:0];
            if (!skip && int'(dy) < 16 * (int'(tm) + 1)) begin
                rt    = vf ? tm - dy[7:4] : dy[7:4];  // tile row
                mcode = {(code[15:12] & msk) | off, code[11:0]};
                for (n = 0; n <= int'(tn); n++) begin
                    ecode = {mcode[15:8], mcode[7:4] + rt, mcode[3:0] + 4'(n)};
                    npos  = hf ? tn - 4'(n) : 4'(n);
                    hpos  = x[8:0] + 9'(npos) * 9'd16 - 9'd1;
                    exp_q.push_back({ecode, 4'h0, dy[3:0] ^ {4{vf}}, attr[7:0], hpos});
                end
            end
        end
    endtask

    task automatic run_case(input int c, output logic done_ok);
        int     cyc;
        integer rnd;
        done_ok     = 1'b1;
        flip        = c_flip[c];
        line        = c_line[c];
        game        = c_game[c];
        bank_offset = c_boff[c];
        bank_mask   = c_bmask[c];
        load_case(c);
        build_expected(c);
        got_q.delete();
        start = 1'b1;   // one cycle request
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (busy) else begin
            $display("case %s: busy did not rise the cycle after start", c_name[c]);
            done_ok = 1'b0;
        end
        if (done_ok) begin
            cyc = 0;
            while ((busy || tile_valid) && cyc < TIMEOUT) begin
                if (c_rand[c]) begin
                    rnd        = $random(seed);
                    tile_ready = rnd[0];
                end else begin
                    tile_ready = c_ready[c][cyc % 8];
                end
                if (tile_valid && tile_ready) begin
                    got_q.push_back({tile_code, tile_attr, tile_hpos});  // taken at next edge
                end
                @(posedge clk);
                #1;
                cyc++;
            end
            tile_ready = 1'b0;
            if (busy || tile_valid) begin
                $display("case %s: scan did not finish within %0d cycles", c_name[c], TIMEOUT);
                done_ok = 1'b0;
            end
        end
    endtask

    task automatic check_records(input int c);
        int i;
        assert (got_q.size() == exp_q.size()) else begin
            $display("FAILED %s record count: expected %0d, actual %0d",
                     c_name[c], exp_q.size(), got_q.size());
            case_errs++;
        end
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("FAILED %s record %0d: expected %h/%h/%h, actual %h/%h/%h",
                         c_name[c], i, exp_q[i][40:25], exp_q[i][24:9], exp_q[i][8:0],
                         got_q[i][40:25], got_q[i][24:9], got_q[i][8:0]);
                case_errs++;
            end
        end
    endtask

    initial begin
        int cyc;
        flip        = 1'b0;
        line        = '0;
        start       = 1'b0;
        game        = gfx_pkg::game_plain;
        bank_offset = '0;
        bank_mask   = '0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        tile_ready  = 1'b0;
        seed        = 32'hac532227;
        errors      = 0;
        passed      = 0;
        timed_out   = 1'b0;
        fill_table();
        cyc = 0;
        while (rst && cyc < 20) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        assert (!rst && !busy && !tile_valid) else begin
            $display("reset did not release or left busy or tile_valid high");
            errors++;
        end
        for (ci = 0; ci < NCASE && !timed_out; ci++) begin
            case_errs = 0;
            run_case(ci, ok);
            if (!ok) begin
                timed_out = 1'b1;
            end else begin
                check_records(ci);
            end
            errors += case_errs;
            if (ok && case_errs == 0) begin
                passed++;
            end
            $display("case %s %s, %0d records", c_name[ci],
                     (ok && case_errs == 0) ? "ok" : "bad", got_q.size());
        end
        $display("%0d of %0d cases ok, %0d check failures", passed, NCASE, errors);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== obj_line.f ====
hw/obj_pkg.sv
hw/gfx_pkg.sv
hw/obj_draw_if.sv
hw/obj_frame_ram.sv
hw/gfx_bank_mapper.sv
hw/obj_row_match.sv
hw/obj_line_scan.sv
hw/obj_tile_out.sv
hw/obj_line_top.sv
sim/tb_clk_gen.sv
sim/obj_line_tb.sv

// ==== Bender.yml ====
package:
  name: obj_line

sources:
  # design, compile order
  - files:
      - hw/obj_pkg.sv
      - hw/gfx_pkg.sv
      - hw/obj_draw_if.sv
      - hw/obj_frame_ram.sv
      - hw/gfx_bank_mapper.sv
      - hw/obj_row_match.sv
      - hw/obj_line_scan.sv
      - hw/obj_tile_out.sv
      - hw/obj_line_top.sv
  # testbench
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/obj_line_tb.sv
